/* bench/throttled_mem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module throttled_mem_assert (
   input  wire                            clk,
   input  wire                            reset,
   input  wire mem_model_pkg::bw_limit_t  bw_limit,
   input  wire mem_model_pkg::budget_t    budget_level,
   input  wire                            wr_offer_valid,
   input  wire                            rd_offer_valid,
   input  wire                            wr_grant,
   input  wire                            rd_grant,
   input  wire                            mem_wr_en,
   input  wire                            mem_rd_en
);

   localparam int unsigned BUDGET_RANGE = 2 ** $bits(mem_model_pkg::budget_t);

   // grant only while the matching offer is up
   wr_grant_has_offer : assert property (@(posedge clk) disable iff (!reset)
      wr_grant |-> wr_offer_valid)
      else $error("write grant without a write offer");

   rd_grant_has_offer : assert property (@(posedge clk) disable iff (!reset)
      rd_grant |-> rd_offer_valid)
      else $error("read grant without a read offer");

   // level and one cycle of credit stay inside the counter range
   credit_in_range : assert property (@(posedge clk) disable iff (!reset)
      (32'(budget_level) + mem_model_pkg::MAX_PORTS * 32'(bw_limit)) < BUDGET_RANGE)
      else $error("budget level plus per-cycle credit overflows the budget counter");

   // array strobes are the grants themselves
   enables_follow_grants : assert property (@(posedge clk) disable iff (!reset)
      (mem_wr_en == wr_grant) && (mem_rd_en == rd_grant))
      else $error("memory enables differ from the grants");

endmodule

bind bw_throttle_arbiter throttled_mem_assert throttled_mem_assert_inst (
   .clk(clk), .reset(reset), .bw_limit(bw_limit), .budget_level(budget_level),
   .wr_offer_valid(wr_offer_valid), .rd_offer_valid(rd_offer_valid),
   .wr_grant(wr_grant), .rd_grant(rd_grant),
   .mem_wr_en(mem_wr_en), .mem_rd_en(mem_rd_en)
);

`default_nettype wire

/* bench/throttled_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module throttled_mem_tb;

   localparam int QUEUE_DEPTH    = 4;
   localparam int CYCLES_PER_REQ = 40;  // watchdog allowance per request

   typedef enum logic [2:0] {
      op_write, op_read, op_full, op_drain, op_rate, op_mix
   } op_t;

   typedef struct packed {
      op_t                       op;
      mem_model_pkg::word_addr_t addr;
      mem_model_pkg::word_t      data;
      mem_model_pkg::byte_mask_t mask;
      mem_model_pkg::burst_len_t len;
      mem_model_pkg::bw_limit_t  limit;
      logic [7:0]                rdy_pat;  // rd_resp_ready pattern with one bit per cycle
      logic [7:0]                rep;      // repeat count with random data above 1
   } row_t;

   // an accepted request still waiting to complete
   typedef struct packed {
      mem_model_pkg::word_addr_t addr;
      mem_model_pkg::burst_len_t len;
      mem_model_pkg::word_t      data;
   } pend_t;

   logic                      clk;
   logic                      reset;
   logic                      wr_req_valid;
   logic                      wr_req_ready;
   mem_model_pkg::wr_req_t    wr_req;
   logic                      rd_req_valid;
   logic                      rd_req_ready;
   mem_model_pkg::rd_req_t    rd_req;
   logic                      rd_resp_valid;
   logic                      rd_resp_ready;
   mem_model_pkg::word_t      rd_resp_data;
   logic                      wr_done;
   mem_model_pkg::bw_limit_t  bw_limit;

   row_t         rows [$];
   pend_t        wr_q [$];         // writes waiting for wr_done
   pend_t        rd_q [$];         // expected responses in request order
   logic [7:0]   ref_mem [256][8];  // reference memory with one byte per lane
   int           pending_wr [256];
   int           pending_rd [256];
   logic [255:0] written;
   logic [7:0]   rdy_pat;
   logic [2:0]   pat_pos;
   integer       seed;
   int           cycle_cnt;
   int           done_cost;
   int           activity;        // wr_done pulses plus rd_resp_valid cycles
   int           activity_mark;
   int           error_count;
   int           watchdog_cycles;

   throttled_mem #(.QUEUE_DEPTH(QUEUE_DEPTH)) throttled_mem_inst (
      .clk, .reset, .wr_req_valid, .wr_req_ready, .wr_req,
      .rd_req_valid, .rd_req_ready, .rd_req,
      .rd_resp_valid, .rd_resp_ready, .rd_resp_data, .wr_done, .bw_limit
   );

   always #50 clk = ~clk;

   task automatic check_value(input string name, input mem_model_pkg::word_t got,
                              input mem_model_pkg::word_t exp);
      if (got !== exp) begin
         error_count++;
         $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fail_run(input string why);
      error_count++;
      $display("%0t: %s", $time, why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   function automatic int cost_of(input mem_model_pkg::burst_len_t len);
      return (int'(len) + 1) * int'(mem_model_pkg::SCALE_FACTOR);
   endfunction

   function automatic mem_model_pkg::word_t random_word();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic issue_write(input mem_model_pkg::word_addr_t a, input mem_model_pkg::word_t d,
                              input mem_model_pkg::byte_mask_t m,
                              input mem_model_pkg::burst_len_t l);
      pend_t p;
      logic  taken;
      while (pending_rd[a] != 0) next_cycle();  // earlier reads of a must finish
      wr_req_valid = 1'b1;
      wr_req = '{addr: a, data: d, mask: m, len: l};
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = wr_req_ready;
         next_cycle();
      end
      wr_req_valid = 1'b0;
      for (int b = 0; b < 8; b++) begin
         if (m[b]) ref_mem[a][b] = d[b*8 +: 8];
      end
      p = '{addr: a, len: l, data: d};
      wr_q.push_back(p);
      pending_wr[a]++;
      written[a] = 1'b1;
   endtask

   task automatic issue_read(input mem_model_pkg::word_addr_t a,
                             input mem_model_pkg::burst_len_t l);
      pend_t p;
      logic  taken;
      while (pending_wr[a] != 0) next_cycle();
      rd_req_valid = 1'b1;
      rd_req = '{addr: a, len: l};
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = rd_req_ready;
         next_cycle();
      end
      rd_req_valid = 1'b0;
      p.addr = a;
      p.len = l;
      for (int b = 0; b < 8; b++) p.data[b*8 +: 8] = ref_mem[a][b];
      rd_q.push_back(p);
      pending_rd[a]++;
   endtask

   // with no credit both queues fill and nothing completes
   task automatic check_full();
      repeat (10) next_cycle();
      check_value("wr_req_ready", mem_model_pkg::word_t'(wr_req_ready), '0);
      check_value("rd_req_ready", mem_model_pkg::word_t'(rd_req_ready), '0);
      check_value("completions", mem_model_pkg::word_t'(activity),
                  mem_model_pkg::word_t'(activity_mark));
   endtask

   task automatic drain_all();
      while (wr_q.size() != 0 || rd_q.size() != 0) next_cycle();
      repeat (2) next_cycle();  // let the last rd_resp_valid fall
      activity_mark = activity;
   endtask

   task automatic rate_window(input row_t r);
      int start_cycle;
      int start_cost;
      int n;
      int bound;
      start_cycle = cycle_cnt;
      start_cost = done_cost;
      for (int i = 0; i < int'(r.rep); i++) begin
         issue_write(r.addr + 8'd8 + mem_model_pkg::word_addr_t'(i % 8), random_word(),
                     r.mask, r.len);
         issue_read(r.addr + mem_model_pkg::word_addr_t'(i % 4), r.len);
      end
      n = cycle_cnt - start_cycle;
      bound = int'(mem_model_pkg::MAX_PORTS) * int'(r.limit) * n +
              int'(mem_model_pkg::MAX_PORTS) * cost_of(4'hf);
      if (done_cost - start_cost > bound) begin
         fail_run($sformatf("completed cost %0d in %0d cycles is above the limit of %0d",
                            done_cost - start_cost, n, bound));
      end
   endtask

   task automatic mixed_traffic(input row_t r);
      logic [31:0]               rnd;
      mem_model_pkg::word_addr_t a;
      for (int i = 0; i < int'(r.rep); i++) begin
         rnd = $random(seed);
         a = r.addr + mem_model_pkg::word_addr_t'(rnd[2:0]);
         if (rnd[17] || !written[a]) begin
            issue_write(a, random_word(), written[a] ? rnd[16:9] : 8'hff, rnd[8:5]);
         end else begin
            issue_read(a, rnd[8:5]);
         end
         repeat (rnd[4:3]) next_cycle();  // random gap
      end
   endtask

   task automatic add_row(input op_t op, input mem_model_pkg::word_addr_t a,
                          input mem_model_pkg::word_t d, input mem_model_pkg::byte_mask_t m,
                          input mem_model_pkg::burst_len_t l,
                          input mem_model_pkg::bw_limit_t lim,
                          input logic [7:0] pat, input logic [7:0] rep);
      row_t r;
      r = '{op, a, d, m, l, lim, pat, rep};
      rows.push_back(r);
   endtask

   task automatic build_table();
      add_row(op_write, 8'h05, 64'h0011_2233_4455_6677, 8'hff, 4'd0, 8'd16, 8'hff, 8'd1);
      add_row(op_write, 8'h05, 64'ha5a5_5a5a_c3c3_3c3c, 8'h5a, 4'd1, 8'd16, 8'hff, 8'd1);
      add_row(op_read,  8'h05, '0, '0, 4'd0, 8'd16, 8'hff, 8'd1);  // partial mask merge
      add_row(op_write, 8'h10, '0, 8'hff, 4'd0, 8'd16, 8'hff, 8'd8);
      add_row(op_read,  8'h10, '0, '0, 4'd2, 8'd16, 8'b0110_0101, 8'd8);
      add_row(op_drain, 8'h00, '0, '0, 4'd0, 8'd16, 8'hff, 8'd1);
      add_row(op_write, 8'h30, '0, 8'hff, 4'd0, 8'd0, 8'hff, 8'(QUEUE_DEPTH));
      add_row(op_read,  8'h10, '0, '0, 4'd0, 8'd0, 8'hff, 8'(QUEUE_DEPTH));
      add_row(op_full,  8'h00, '0, '0, 4'd0, 8'd0, 8'hff, 8'd1);
      add_row(op_drain, 8'h00, '0, '0, 4'd0, 8'd3, 8'hff, 8'd1);
      add_row(op_rate,  8'h10, '0, 8'hff, 4'd1, 8'd1, 8'hff, 8'd32);
      add_row(op_drain, 8'h00, '0, '0, 4'd0, 8'd1, 8'hff, 8'd1);
      add_row(op_mix,   8'h40, '0, '0, 4'd0, 8'd200, 8'b1110_1101, 8'd60);
      add_row(op_drain, 8'h00, '0, '0, 4'd0, 8'd200, 8'hff, 8'd1);
   endtask

   task automatic apply_row(input row_t r);
      bw_limit = r.limit;
      rdy_pat = r.rdy_pat;
      case (r.op)
         op_write: begin
            for (int i = 0; i < int'(r.rep); i++) begin
               issue_write(r.addr + mem_model_pkg::word_addr_t'(i),
                           (r.rep > 8'd1) ? random_word() : r.data, r.mask, r.len);
            end
         end
         op_read: begin
            for (int i = 0; i < int'(r.rep); i++) begin
               issue_read(r.addr + mem_model_pkg::word_addr_t'(i), r.len);
            end
         end
         op_full:  check_full();
         op_drain: drain_all();
         op_rate:  rate_window(r);
         op_mix:   mixed_traffic(r);
         default:  fail_run("unknown operation in the stimulus table");
      endcase
   endtask

   // response ready follows the row pattern
   always @(posedge clk) begin
      #1;
      rd_resp_ready = rdy_pat[pat_pos];
      pat_pos = pat_pos + 3'd1;
   end

   // completions sampled mid-cycle before the transfer edge
   always @(negedge clk) begin : monitor
      pend_t p;
      if (reset) begin
         cycle_cnt++;
         if (rd_resp_valid) activity++;
         if (wr_done) begin
            activity++;
            if (wr_q.size() == 0) fail_run("wr_done pulsed with no write outstanding");
            p = wr_q.pop_front();
            pending_wr[p.addr]--;
            done_cost += cost_of(p.len);
         end
         if (rd_resp_valid && rd_resp_ready) begin
            if (rd_q.size() == 0) fail_run("read response arrived with none expected");
            p = rd_q.pop_front();
            check_value("rd_resp_data", rd_resp_data, p.data);
            pending_rd[p.addr]--;
            done_cost += cost_of(p.len);
         end
      end
   end

   initial begin : watchdog
      wait (watchdog_cycles != 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("run timed out after %0d cycles, requests still outstanding", watchdog_cycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin : main
      int total;
      clk = 1'b0;
      reset = 1'b0;
      wr_req_valid = 1'b0;
      wr_req = '0;
      rd_req_valid = 1'b0;
      rd_req = '0;
      rd_resp_ready = 1'b0;
      bw_limit = '0;
      rdy_pat = 8'hff;
      pat_pos = '0;
      written = '0;
      seed = 32'hbab1;
      build_table();
      total = 8;
      foreach (rows[k]) total += CYCLES_PER_REQ * ((rows[k].rep == 8'd0) ? 1 : int'(rows[k].rep));
      watchdog_cycles = total;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b1;
      check_value("wr_done", mem_model_pkg::word_t'(wr_done), '0);
      check_value("rd_resp_valid", mem_model_pkg::word_t'(rd_resp_valid), '0);
      check_value("wr_req_ready", mem_model_pkg::word_t'(wr_req_ready), 64'd1);
      foreach (rows[k]) apply_row(rows[k]);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Simulation finished: FAIL");
         $fatal(1, "checks failed");
      end
   end

endmodule

`default_nettype wire

/* hw/bw_throttle_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bw_throttle_arbiter (
   input  wire                            clk,
   input  wire                            reset,
   input  wire mem_model_pkg::bw_limit_t  bw_limit,
   input  wire                            wr_offer_valid,
   input  wire mem_model_pkg::wr_req_t    wr_offer,
   input  wire                            rd_offer_valid,
   input  wire mem_model_pkg::rd_req_t    rd_offer,
   output logic                           wr_grant,
   output logic                           rd_grant,
   output logic                           mem_wr_en,
   output mem_model_pkg::word_addr_t      mem_wr_addr,
   output mem_model_pkg::word_t           mem_wr_data,
   output mem_model_pkg::byte_mask_t      mem_wr_mask,
   output logic                           mem_rd_en,
   output mem_model_pkg::word_addr_t      mem_rd_addr
);

   // weighted cost of one grant
   function automatic mem_model_pkg::budget_t access_cost(
      input mem_model_pkg::burst_len_t len
   );
      mem_model_pkg::budget_t beats;
      beats = mem_model_pkg::budget_t'(len) + 1'b1;
      return beats * mem_model_pkg::budget_t'(mem_model_pkg::SCALE_FACTOR);
   endfunction

   mem_model_pkg::budget_t    budget_level;  // registered level
   mem_model_pkg::prio_t      prio;
   mem_model_pkg::budget_t    credit;
   mem_model_pkg::budget_t    lvl_dec;
   mem_model_pkg::budget_t    lvl_mid;
   mem_model_pkg::budget_t    lvl_next;
   mem_model_pkg::burst_len_t first_len;
   mem_model_pkg::burst_len_t second_len;
   logic                      write_first;
   logic                      first_valid;
   logic                      second_valid;
   logic                      first_grant;
   logic                      second_grant;

   assign credit = mem_model_pkg::budget_t'(mem_model_pkg::MAX_PORTS) *
                   mem_model_pkg::budget_t'(bw_limit);

   // credit back first, floor at zero
   assign lvl_dec = (budget_level < credit) ? '0 : budget_level - credit;

   assign write_first  = (prio == mem_model_pkg::prio_write);
   assign first_valid  = write_first ? wr_offer_valid : rd_offer_valid;
   assign second_valid = write_first ? rd_offer_valid : wr_offer_valid;
   assign first_len    = write_first ? wr_offer.len : rd_offer.len;
   assign second_len   = write_first ? rd_offer.len : wr_offer.len;

   // second side sees the level after the first one is charged
   assign first_grant  = first_valid && (lvl_dec < credit);
   assign lvl_mid      = first_grant ? lvl_dec + access_cost(first_len) : lvl_dec;
   assign second_grant = second_valid && (lvl_mid < credit);
   assign lvl_next     = second_grant ? lvl_mid + access_cost(second_len) : lvl_mid;

   assign wr_grant = write_first ? first_grant : second_grant;
   assign rd_grant = write_first ? second_grant : first_grant;

   // array accesses follow the grants directly
   assign mem_wr_en   = wr_grant;
   assign mem_wr_addr = wr_offer.addr;
   assign mem_wr_data = wr_offer.data;
   assign mem_wr_mask = wr_offer.mask;
   assign mem_rd_en   = rd_grant;
   assign mem_rd_addr = rd_offer.addr;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         budget_level <= '0;
         prio         <= mem_model_pkg::prio_write;
      end else begin
         budget_level <= lvl_next;
         prio <= write_first ? mem_model_pkg::prio_read : mem_model_pkg::prio_write;
      end
   end

endmodule

`default_nettype wire

/* hw/mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_array (
   input  wire                             clk,
   input  wire                             mem_wr_en,
   input  wire mem_model_pkg::word_addr_t  mem_wr_addr,
   input  wire mem_model_pkg::word_t       mem_wr_data,
   input  wire mem_model_pkg::byte_mask_t  mem_wr_mask,
   input  wire                             mem_rd_en,
   input  wire mem_model_pkg::word_addr_t  mem_rd_addr,
   output mem_model_pkg::word_t            mem_rd_data
);

   localparam int MEM_WORDS = 2 ** $bits(mem_model_pkg::word_addr_t);

   mem_model_pkg::word_t storage [MEM_WORDS];

   // byte lanes with a clear mask bit keep their old value
   always_ff @(posedge clk) begin
      if (mem_wr_en) begin
         for (int b = 0; b < mem_model_pkg::WORD_BYTES; b++) begin
            if (mem_wr_mask[b]) begin
               storage[mem_wr_addr][b*8 +: 8] <= mem_wr_data[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_rd_en) begin
         mem_rd_data <= storage[mem_rd_addr];  // old data on same-edge write
      end
   end

endmodule

`default_nettype wire

/* hw/mem_model_pkg.sv */
`default_nettype none

package mem_model_pkg;

   localparam int unsigned WORD_BYTES   = 8;
   localparam int unsigned MAX_PORTS    = 2;  // write side plus read side
   localparam int unsigned SCALE_FACTOR = 4;  // budget units per burst beat

   // meaningful widths
   typedef logic [8*WORD_BYTES-1:0] word_t;
   typedef logic [WORD_BYTES-1:0]   byte_mask_t;  // one enable per byte lane
   typedef logic [7:0]              word_addr_t;  // 256 words
   typedef logic [3:0]              burst_len_t;  // length minus one, weights cost only
   typedef logic [15:0]             budget_t;     // scaled outstanding blocks
   typedef logic [7:0]              bw_limit_t;   // credit per port per cycle

   // write request as it travels from the requester to the array
   typedef struct packed {
      word_addr_t addr;
      word_t      data;
      byte_mask_t mask;
      burst_len_t len;
   } wr_req_t;

   typedef struct packed {
      word_addr_t addr;
      burst_len_t len;
   } rd_req_t;

   // side that claims the budget first in a cycle
   typedef enum logic {
      prio_write = 1'b0,
      prio_read  = 1'b1
   } prio_t;

endpackage

`default_nettype wire

/* hw/read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module read_port #(
   parameter int QUEUE_DEPTH = 4
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          rd_req_valid,
   output logic                         rd_req_ready,
   input  wire mem_model_pkg::rd_req_t  rd_req,
   output logic                         rd_offer_valid,
   output mem_model_pkg::rd_req_t       rd_offer,
   input  wire                          rd_grant,
   input  wire mem_model_pkg::word_t    mem_rd_data,
   output logic                         rd_resp_valid,
   input  wire                          rd_resp_ready,
   output mem_model_pkg::word_t         rd_resp_data
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);

   mem_model_pkg::rd_req_t fifo_mem [QUEUE_DEPTH];

   logic [PTR_W:0] head;
   logic [PTR_W:0] tail;
   logic           full;
   logic           empty;
   logic           push;
   logic           in_flight;  // array read issued, data arrives next edge

   assign empty = (head == tail);
   assign full  = (head[PTR_W] != tail[PTR_W]) &&
                  (head[PTR_W-1:0] == tail[PTR_W-1:0]);
   assign push  = rd_req_valid && rd_req_ready;

   assign rd_req_ready = !full;
   assign rd_offer     = fifo_mem[head[PTR_W-1:0]];

   // only offer when the response slot is sure to be free
   assign rd_offer_valid = !empty && !in_flight && !rd_resp_valid;

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[tail[PTR_W-1:0]] <= rd_req;
      end
   end

   // response data register
   always_ff @(posedge clk) begin
      if (in_flight) begin
         rd_resp_data <= mem_rd_data;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         head          <= '0;
         tail          <= '0;
         in_flight     <= 1'b0;
         rd_resp_valid <= 1'b0;
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (rd_grant) begin
            head <= head + 1'b1;
         end
         in_flight <= rd_grant;
         if (in_flight) begin
            rd_resp_valid <= 1'b1;
         end else if (rd_resp_ready) begin
            rd_resp_valid <= 1'b0;  // taken by the requester
         end
      end
   end

endmodule

`default_nettype wire

/* hw/throttled_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module throttled_mem #(
   parameter int QUEUE_DEPTH = 4
) (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            wr_req_valid,
   output logic                           wr_req_ready,
   input  wire mem_model_pkg::wr_req_t    wr_req,
   input  wire                            rd_req_valid,
   output logic                           rd_req_ready,
   input  wire mem_model_pkg::rd_req_t    rd_req,
   output logic                           rd_resp_valid,
   input  wire                            rd_resp_ready,
   output mem_model_pkg::word_t           rd_resp_data,
   output logic                           wr_done,
   input  wire mem_model_pkg::bw_limit_t  bw_limit
);

   logic                       wr_offer_valid;
   mem_model_pkg::wr_req_t     wr_offer;
   logic                       wr_grant;
   logic                       rd_offer_valid;
   mem_model_pkg::rd_req_t     rd_offer;
   logic                       rd_grant;
   logic                       mem_wr_en;
   mem_model_pkg::word_addr_t  mem_wr_addr;
   mem_model_pkg::word_t       mem_wr_data;
   mem_model_pkg::byte_mask_t  mem_wr_mask;
   logic                       mem_rd_en;
   mem_model_pkg::word_addr_t  mem_rd_addr;
   mem_model_pkg::word_t       mem_rd_data;

   write_port #(.QUEUE_DEPTH(QUEUE_DEPTH)) write_port_inst (
      .clk, .reset, .wr_req_valid, .wr_req_ready, .wr_req,
      .wr_offer_valid, .wr_offer, .wr_grant, .wr_done
   );

   read_port #(.QUEUE_DEPTH(QUEUE_DEPTH)) read_port_inst (
      .clk, .reset, .rd_req_valid, .rd_req_ready, .rd_req,
      .rd_offer_valid, .rd_offer, .rd_grant, .mem_rd_data,
      .rd_resp_valid, .rd_resp_ready, .rd_resp_data
   );

   // budget and priority between the two ports
   bw_throttle_arbiter bw_throttle_arbiter_inst (
      .clk, .reset, .bw_limit,
      .wr_offer_valid, .wr_offer, .rd_offer_valid, .rd_offer,
      .wr_grant, .rd_grant,
      .mem_wr_en, .mem_wr_addr, .mem_wr_data, .mem_wr_mask,
      .mem_rd_en, .mem_rd_addr
   );

   mem_array mem_array_inst (
      .clk, .mem_wr_en, .mem_wr_addr, .mem_wr_data, .mem_wr_mask,
      .mem_rd_en, .mem_rd_addr, .mem_rd_data
   );

endmodule

`default_nettype wire

/* hw/write_port.sv */
`timescale 1ns/1ps
`default_nettype none

module write_port #(
   parameter int QUEUE_DEPTH = 4
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          wr_req_valid,
   output logic                         wr_req_ready,
   input  wire mem_model_pkg::wr_req_t  wr_req,
   output logic                         wr_offer_valid,
   output mem_model_pkg::wr_req_t       wr_offer,
   input  wire                          wr_grant,
   output logic                         wr_done
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);

   mem_model_pkg::wr_req_t fifo_mem [QUEUE_DEPTH];

   logic [PTR_W:0] head;  // extra msb tells full from empty
   logic [PTR_W:0] tail;
   logic           full;
   logic           empty;
   logic           push;

   assign empty = (head == tail);
   assign full  = (head[PTR_W] != tail[PTR_W]) &&
                  (head[PTR_W-1:0] == tail[PTR_W-1:0]);
   assign push  = wr_req_valid && wr_req_ready;

   assign wr_req_ready   = !full;
   assign wr_offer_valid = !empty;
   assign wr_offer       = fifo_mem[head[PTR_W-1:0]];  // oldest request

   // queue storage
   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[tail[PTR_W-1:0]] <= wr_req;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         head    <= '0;
         tail    <= '0;
         wr_done <= 1'b0;
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (wr_grant) begin
            head <= head + 1'b1;  // array takes the head on this edge
         end
         // completion shows up the cycle after the array write
         wr_done <= wr_grant;
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the throttled memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=throttled_mem_sim

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module throttled_mem_tb -f src.f -o "$SIM"; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

/* src.f */
hw/mem_model_pkg.sv
hw/mem_array.sv
hw/write_port.sv
hw/read_port.sv
hw/bw_throttle_arbiter.sv
hw/throttled_mem.sv
bench/throttled_mem_assert.sv
bench/throttled_mem_tb.sv
